/* source/anc_consts.svh */
`ifndef ANC_CONSTS_SVH
`define ANC_CONSTS_SVH

// sample and datapath widths
`define ANC_SAMPLE_W     14
`define ANC_WEIGHT_W     16
`define ANC_ERR_W        16
`define ANC_ACC_W        36

// filter length, desired sample sits mid-line
`define ANC_TAPS         8
`define ANC_DESIRED_TAP  4
`define ANC_TAP_IDX_W    4

`define ANC_FRAC         12  // estimate scaling
`define ANC_MU_SHIFT     10  // step size
`define ANC_OUT_OFFSET   3000

`endif

/* source/anc_pkg.sv */
`default_nettype none

package anc_pkg;

    // one-hot frame phase, msb first
    typedef struct packed {
        logic done;
        logic shift;
        logic update;
        logic filter;
        logic idle;
    } phase_flags_t;

    typedef union packed {
        logic [4:0]   code;  // whole one-hot word
        phase_flags_t flag;  // per-phase strobes
    } phase_u;

endpackage

`default_nettype wire

/* source/tap_delay_line.sv */
`default_nettype none
`include "anc_consts.svh"

module tap_delay_line #(
    parameter int DEPTH = `ANC_TAPS
) (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     shift,
    input  logic [`ANC_SAMPLE_W-1:0] sample,
    output logic [`ANC_SAMPLE_W-1:0] taps [DEPTH]
);

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            for (int i = 0; i < DEPTH; i++)
                taps[i] <= '0;
        end
        else if (shift)
        begin
            taps[0] <= sample;  // newest sample
            for (int i = 1; i < DEPTH; i++)
                taps[i] <= taps[i-1];
        end
    end

endmodule

`default_nettype wire

/* source/anc_sequencer.sv */
`default_nettype none
`include "anc_consts.svh"

module anc_sequencer (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      head_flag,
    output anc_pkg::phase_u           phase,
    output logic [`ANC_TAP_IDX_W-1:0] tap_idx
);

    localparam logic [4:0] PH_IDLE   = 5'b00001;
    localparam logic [4:0] PH_FILTER = 5'b00010;
    localparam logic [4:0] PH_UPDATE = 5'b00100;
    localparam logic [4:0] PH_SHIFT  = 5'b01000;
    localparam logic [4:0] PH_DONE   = 5'b10000;

    // filter runs one extra cycle for the error latch
    localparam logic [`ANC_TAP_IDX_W-1:0] FILTER_LAST = `ANC_TAP_IDX_W'(`ANC_TAPS);
    localparam logic [`ANC_TAP_IDX_W-1:0] UPDATE_LAST = `ANC_TAP_IDX_W'(`ANC_TAPS - 1);

    anc_pkg::phase_u phase_nxt;
    logic            phase_change;

    always_comb
    begin
        phase_nxt.code = phase.code;
        case (phase.code)
            PH_IDLE:
            begin
                if (head_flag)
                    phase_nxt.code = PH_FILTER;
            end
            PH_FILTER:
            begin
                if (tap_idx == FILTER_LAST)
                    phase_nxt.code = PH_UPDATE;
            end
            PH_UPDATE:
            begin
                if (tap_idx == UPDATE_LAST)
                    phase_nxt.code = PH_SHIFT;
            end
            PH_SHIFT:
            begin
                phase_nxt.code = PH_DONE;
            end
            PH_DONE:
            begin
                if (!head_flag)  // wait for head_flag release
                    phase_nxt.code = PH_IDLE;
            end
            default:
            begin
                phase_nxt.code = PH_IDLE;
            end
        endcase
    end

    assign phase_change = (phase_nxt.code != phase.code);

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            phase.code <= PH_IDLE;
            tap_idx    <= '0;
        end
        else
        begin
            phase.code <= phase_nxt.code;
            if (phase_change)
                tap_idx <= '0;  // restart per phase
            else if (phase.flag.filter || phase.flag.update)
                tap_idx <= tap_idx + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/lms_channel.sv */
`default_nettype none
`include "anc_consts.svh"

module lms_channel (
    input  logic                      clk,
    input  logic                      rstn,
    input  anc_pkg::phase_u           phase,
    input  logic [`ANC_TAP_IDX_W-1:0] tap_idx,
    input  logic [`ANC_SAMPLE_W-1:0]  ref_taps [`ANC_TAPS],
    input  logic [`ANC_SAMPLE_W-1:0]  desired,
    output logic [`ANC_SAMPLE_W-1:0]  clean
);

    localparam int SEL_W  = $clog2(`ANC_TAPS);
    localparam int PROD_W = `ANC_WEIGHT_W + `ANC_SAMPLE_W;
    localparam int UPD_W  = `ANC_ERR_W + `ANC_SAMPLE_W;

    localparam logic [`ANC_TAP_IDX_W-1:0] TAP_COUNT = `ANC_TAP_IDX_W'(`ANC_TAPS);

    logic signed [`ANC_WEIGHT_W-1:0] weight [`ANC_TAPS];
    logic signed [`ANC_ACC_W-1:0]    acc;
    logic signed [`ANC_ERR_W-1:0]    err;

    logic        [SEL_W-1:0]         tap_sel;
    logic signed [`ANC_SAMPLE_W-1:0] ref_sel;
    logic signed [PROD_W-1:0]        mac_prod;
    logic signed [`ANC_ACC_W-1:0]    acc_base;
    logic signed [`ANC_ACC_W-1:0]    err_full;
    logic signed [UPD_W-1:0]         upd_prod;
    logic signed [UPD_W-1:0]         upd_step;
    logic                            mac_en;
    logic                            err_en;

    // tap_idx goes one past the last tap in filter
    assign tap_sel = tap_idx[SEL_W-1:0];
    assign ref_sel = $signed(ref_taps[tap_sel]);

    assign mac_en = phase.flag.filter && (tap_idx < TAP_COUNT);
    assign err_en = phase.flag.filter && (tap_idx == TAP_COUNT);

    // serial fir term
    assign mac_prod = weight[tap_sel] * ref_sel;
    assign acc_base = (tap_idx == '0) ? '0 : acc;  // fresh sum at first tap

    // desired minus scaled estimate
    assign err_full = `ANC_ACC_W'($signed(desired)) - (acc >>> `ANC_FRAC);

    // lms step for the current tap
    assign upd_prod = err * ref_sel;
    assign upd_step = upd_prod >>> `ANC_MU_SHIFT;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            acc <= '0;
        else if (mac_en)
            acc <= acc_base + `ANC_ACC_W'(mac_prod);
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            err   <= '0;
            clean <= '0;
        end
        else if (err_en)
        begin
            err   <= err_full[`ANC_ERR_W-1:0];
            clean <= err_full[`ANC_SAMPLE_W-1:0];  // cleaned sample out
        end
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            for (int i = 0; i < `ANC_TAPS; i++)
                weight[i] <= '0;
        end
        else if (phase.flag.update)
        begin
            weight[tap_sel] <= weight[tap_sel] + upd_step[`ANC_WEIGHT_W-1:0];  // wraps
        end
    end

endmodule

`default_nettype wire

/* source/anc_top.sv */
`default_nettype none
`include "anc_consts.svh"

module anc_top (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     head_flag,
    input  logic [`ANC_SAMPLE_W-1:0] buffer_a,
    input  logic [`ANC_SAMPLE_W-1:0] buffer_b,
    input  logic [`ANC_SAMPLE_W-1:0] reff,
    output logic [`ANC_SAMPLE_W-1:0] dout
);

    anc_pkg::phase_u                 phase;
    logic [`ANC_TAP_IDX_W-1:0]       tap_idx;

    logic [`ANC_SAMPLE_W-1:0]        ref_taps [`ANC_TAPS];
    logic [`ANC_SAMPLE_W-1:0]        prim_taps_a [`ANC_TAPS];
    logic [`ANC_SAMPLE_W-1:0]        prim_taps_b [`ANC_TAPS];
    logic [`ANC_SAMPLE_W-1:0]        clean_a;
    logic [`ANC_SAMPLE_W-1:0]        clean_b;

    anc_sequencer seq (
        .clk       (clk),
        .rstn      (rstn),
        .head_flag (head_flag),
        .phase     (phase),
        .tap_idx   (tap_idx)
    );

    tap_delay_line #(.DEPTH(`ANC_TAPS)) ref_line (
        .clk    (clk),
        .rstn   (rstn),
        .shift  (phase.flag.shift),
        .sample (reff),
        .taps   (ref_taps)
    );

    tap_delay_line #(.DEPTH(`ANC_TAPS)) prim_line_a (
        .clk    (clk),
        .rstn   (rstn),
        .shift  (phase.flag.shift),
        .sample (buffer_a),
        .taps   (prim_taps_a)
    );

    tap_delay_line #(.DEPTH(`ANC_TAPS)) prim_line_b (
        .clk    (clk),
        .rstn   (rstn),
        .shift  (phase.flag.shift),
        .sample (buffer_b),
        .taps   (prim_taps_b)
    );

    lms_channel chan_a (
        .clk      (clk),
        .rstn     (rstn),
        .phase    (phase),
        .tap_idx  (tap_idx),
        .ref_taps (ref_taps),
        .desired  (prim_taps_a[`ANC_DESIRED_TAP]),
        .clean    (clean_a)
    );

    lms_channel chan_b (
        .clk      (clk),
        .rstn     (rstn),
        .phase    (phase),
        .tap_idx  (tap_idx),
        .ref_taps (ref_taps),
        .desired  (prim_taps_b[`ANC_DESIRED_TAP]),
        .clean    (clean_b)
    );

    // output sum, updated once per frame
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            dout <= '0;
        else if (phase.flag.shift)
            dout <= clean_a + clean_b + `ANC_SAMPLE_W'(`ANC_OUT_OFFSET);  // mod 2^14
    end

endmodule

`default_nettype wire

/* test/anc_tb.sv */
`default_nettype none
`include "anc_consts.svh"

module anc_tb;

    localparam int FRAME_EDGES = 2 * `ANC_TAPS + 3;  // edge 0 through the shift edge
    localparam int TIMEOUT     = 1000000;

    logic                     clk;
    logic                     rstn;
    logic                     head_flag;
    logic [`ANC_SAMPLE_W-1:0] buffer_a;
    logic [`ANC_SAMPLE_W-1:0] buffer_b;
    logic [`ANC_SAMPLE_W-1:0] reff;
    logic [`ANC_SAMPLE_W-1:0] dout;

    logic [31:0] rng_state;
    int          errors;
    int          checks;

    // model state with signed taps
    logic signed [`ANC_SAMPLE_W-1:0] model_ref [`ANC_TAPS];
    logic signed [`ANC_SAMPLE_W-1:0] model_prim [2][`ANC_TAPS];
    logic signed [`ANC_WEIGHT_W-1:0] model_w [2][`ANC_TAPS];

    anc_top uut (
        .clk       (clk),
        .rstn      (rstn),
        .head_flag (head_flag),
        .buffer_a  (buffer_a),
        .buffer_b  (buffer_b),
        .reff      (reff),
        .dout      (dout)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw_sample(output logic [`ANC_SAMPLE_W-1:0] v);
        rng_state = xorshift32(rng_state);
        v = rng_state[`ANC_SAMPLE_W-1:0];
    endtask

    task automatic wait_cycles(input int n);
        for (int i = 0; i < n; i++)
            @(posedge clk);
    endtask

    task automatic check_value(input string name, input logic [`ANC_SAMPLE_W-1:0] expected,
                               input logic [`ANC_SAMPLE_W-1:0] actual);
        checks++;
        assert (actual === expected)
        else
        begin
            $display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    function automatic logic weights_zero();
        logic all_zero;
        all_zero = 1'b1;
        for (int c = 0; c < 2; c++)
            for (int i = 0; i < `ANC_TAPS; i++)
                if (model_w[c][i] != '0)
                    all_zero = 1'b0;
        return all_zero;
    endfunction

    task automatic clear_model();
        for (int i = 0; i < `ANC_TAPS; i++)
        begin
            model_ref[i] = '0;
            for (int c = 0; c < 2; c++)
            begin
                model_prim[c][i] = '0;
                model_w[c][i]    = '0;
            end
        end
    endtask

    // filter, error and weight update of one channel on the current taps
    task automatic compute_channel(input int c, output logic [`ANC_SAMPLE_W-1:0] clean);
        logic signed [63:0]             acc;
        logic signed [63:0]             err_full;
        logic signed [`ANC_ERR_W-1:0]   err;
        logic signed [63:0]             step;
        acc = '0;
        for (int i = 0; i < `ANC_TAPS; i++)
            acc = acc + 64'(model_w[c][i]) * 64'(model_ref[i]);
        err_full = 64'(model_prim[c][`ANC_DESIRED_TAP]) - (acc >>> `ANC_FRAC);
        err      = err_full[`ANC_ERR_W-1:0];
        clean    = err_full[`ANC_SAMPLE_W-1:0];
        for (int i = 0; i < `ANC_TAPS; i++)
        begin
            step = (64'(err) * 64'(model_ref[i])) >>> `ANC_MU_SHIFT;
            model_w[c][i] = model_w[c][i] + step[`ANC_WEIGHT_W-1:0];  // wraps
        end
    endtask

    task automatic predict_frame(input logic [`ANC_SAMPLE_W-1:0] a,
                                 input logic [`ANC_SAMPLE_W-1:0] b,
                                 input logic [`ANC_SAMPLE_W-1:0] r,
                                 output logic [`ANC_SAMPLE_W-1:0] expected);
        logic [`ANC_SAMPLE_W-1:0] clean_a;
        logic [`ANC_SAMPLE_W-1:0] clean_b;
        compute_channel(0, clean_a);
        compute_channel(1, clean_b);
        expected = clean_a + clean_b + `ANC_SAMPLE_W'(`ANC_OUT_OFFSET);
        for (int i = `ANC_TAPS - 1; i > 0; i--)
        begin
            model_ref[i]     = model_ref[i-1];
            model_prim[0][i] = model_prim[0][i-1];
            model_prim[1][i] = model_prim[1][i-1];
        end
        model_ref[0]     = r;
        model_prim[0][0] = a;
        model_prim[1][0] = b;
    endtask

    // one frame with an optional head_flag hold afterwards
    task automatic run_frame(input string name, input logic [`ANC_SAMPLE_W-1:0] a,
                             input logic [`ANC_SAMPLE_W-1:0] b,
                             input logic [`ANC_SAMPLE_W-1:0] r, input int hold);
        logic [`ANC_SAMPLE_W-1:0] expected;
        logic [`ANC_SAMPLE_W-1:0] plain;
        logic [`ANC_SAMPLE_W-1:0] v;
        logic                     still_zero;
        still_zero = weights_zero();
        plain = model_prim[0][`ANC_DESIRED_TAP] + model_prim[1][`ANC_DESIRED_TAP]
              + `ANC_SAMPLE_W'(`ANC_OUT_OFFSET);
        predict_frame(a, b, r, expected);
        @(posedge clk);
        buffer_a  <= a;
        buffer_b  <= b;
        reff      <= r;
        head_flag <= 1'b1;
        wait_cycles(FRAME_EDGES);
        @(negedge clk);
        check_value(name, expected, dout);
        if (still_zero)
            check_value({name, " desired sum"}, plain, dout);
        for (int i = 0; i < hold; i++)
        begin
            @(posedge clk);
            draw_sample(v);
            buffer_a <= v;
            draw_sample(v);
            buffer_b <= v;
            draw_sample(v);
            reff <= v;
            @(negedge clk);
            check_value({name, " held"}, expected, dout);
        end
        @(posedge clk);
        head_flag <= 1'b0;
        wait_cycles(2);  // done sees head_flag low
    endtask

    task automatic reset_idle();
        logic [`ANC_SAMPLE_W-1:0] v;
        for (int i = 0; i < 30; i++)
        begin
            @(posedge clk);
            draw_sample(v);
            buffer_a <= v;
            draw_sample(v);
            buffer_b <= v;
            draw_sample(v);
            reff <= v;
            @(negedge clk);
            check_value("reset_idle", '0, dout);
        end
    endtask

    task automatic zero_weight_frames();
        logic [`ANC_SAMPLE_W-1:0] a;
        logic [`ANC_SAMPLE_W-1:0] b;
        logic [`ANC_SAMPLE_W-1:0] r;
        for (int f = 0; f < `ANC_TAPS + 1; f++)
        begin
            draw_sample(a);
            draw_sample(b);
            draw_sample(r);
            run_frame("zero_weight_frames", a, b, r, 0);
        end
    endtask

    task automatic adaptation();
        logic [`ANC_SAMPLE_W-1:0]        raw;
        logic signed [`ANC_SAMPLE_W-1:0] noise;
        logic signed [`ANC_SAMPLE_W-1:0] sig_a;
        logic signed [`ANC_SAMPLE_W-1:0] sig_b;
        for (int f = 0; f < 40; f++)
        begin
            draw_sample(raw);
            noise = $signed(raw) >>> 2;  // shared interference
            draw_sample(raw);
            sig_a = $signed(raw) >>> 4;
            draw_sample(raw);
            sig_b = $signed(raw) >>> 4;
            run_frame("adaptation", sig_a + noise, sig_b - (noise >>> 1), noise, 0);
        end
    endtask

    task automatic held_head_flag();
        logic [`ANC_SAMPLE_W-1:0] a;
        logic [`ANC_SAMPLE_W-1:0] b;
        logic [`ANC_SAMPLE_W-1:0] r;
        draw_sample(a);
        draw_sample(b);
        draw_sample(r);
        run_frame("held_head_flag", a, b, r, 60);
        draw_sample(a);
        draw_sample(b);
        draw_sample(r);
        run_frame("held_head_flag next", a, b, r, 0);
    endtask

    task automatic reset_mid_run();
        logic [`ANC_SAMPLE_W-1:0] a;
        logic [`ANC_SAMPLE_W-1:0] b;
        logic [`ANC_SAMPLE_W-1:0] r;
        @(posedge clk);
        rstn <= 1'b0;
        @(negedge clk);
        check_value("reset_mid_run in reset", '0, dout);
        wait_cycles(2);
        rstn <= 1'b1;
        clear_model();
        @(negedge clk);
        check_value("reset_mid_run released", '0, dout);
        draw_sample(a);
        draw_sample(b);
        draw_sample(r);
        run_frame("reset_mid_run", a, b, r, 0);
    endtask

    initial
    begin
        clk       = 1'b0;
        rstn      = 1'b0;
        head_flag = 1'b0;
        buffer_a  = '0;
        buffer_b  = '0;
        reff      = '0;
        rng_state = 32'ha02b_88e9;
        errors    = 0;
        checks    = 0;
        clear_model();
        wait_cycles(3);
        rstn <= 1'b1;
        reset_idle();
        zero_weight_frames();
        adaptation();
        held_head_flag();
        reset_mid_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    initial
    begin
        #(TIMEOUT);
        $display("simulation did not finish in time");
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

/* anc_filter.f */
+incdir+source
source/anc_pkg.sv
source/tap_delay_line.sv
source/anc_sequencer.sv
source/lms_channel.sv
source/anc_top.sv
test/anc_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
verilator --binary --timing --assert -Wno-fatal -f anc_filter.f \
    --top-module anc_tb -Mdir obj_dir -o anc_sim \
    && ./obj_dir/anc_sim | tee /dev/stderr | grep -qF '** PASS **' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
